/* rtl/hps_cmd_pkg.sv */
// Host command channel definitions
// Word and command types, command codes and reset values for the
// strobe/ack word channel from the host processor

package hps_cmd_pkg;

	localparam int IO_WORD_W = 16;

	// One word on the host channel
	typedef logic [IO_WORD_W-1:0] io_word_t;

	// Command byte, low half of the first word of a transfer
	typedef logic [7:0] cmd_t;

	// Position of a parameter word inside a command
	typedef logic [3:0] word_idx_t;

	localparam cmd_t CMD_VIDEO_TIMING = 8'h20;
	localparam cmd_t CMD_LED          = 8'h25;
	localparam cmd_t CMD_VOL_ATT      = 8'h26;
	localparam cmd_t CMD_VSYNC_WAIT   = 8'h30;

	// Full attenuation until the host sets a volume
	localparam logic [4:0] VOL_ATT_RESET = 5'd31;

endpackage

/* rtl/video_timing_pkg.sv */
// Video timing definitions
// Coordinate types, the timing record written by the host and the
// power-up timing of the output

package video_timing_pkg;

	localparam int COORD_W = 12;

	// Line or frame total, one bit wider than a coordinate
	localparam int TOTAL_W = 13;

	typedef logic [COORD_W-1:0] coord_t;

	// Field order matches the parameter words of the timing command
	typedef struct packed {
		coord_t width;
		coord_t hfp;
		coord_t hs;
		coord_t hbp;
		coord_t height;
		coord_t vfp;
		coord_t vs;
		coord_t vbp;
	} video_timing_t;

	// 1920x1080@60 CEA
	localparam video_timing_t TIMING_DEFAULT = '{
		width:  12'd1920,
		hfp:    12'd88,
		hs:     12'd44,
		hbp:    12'd148,
		height: 12'd1080,
		vfp:    12'd4,
		vs:     12'd5,
		vbp:    12'd36
	};

endpackage

/* rtl/cfg_wr_if.sv */
// Configuration write channel
// One decoded parameter word from the command decoder to the register bank

`timescale 1ns/1ps

interface cfg_wr_if;

	logic                   wr_valid;
	hps_cmd_pkg::cmd_t      wr_cmd;
	hps_cmd_pkg::word_idx_t wr_idx;
	hps_cmd_pkg::io_word_t  wr_data;

	modport src (
		output wr_valid,
		output wr_cmd,
		output wr_idx,
		output wr_data
	);

	modport dst (
		input wr_valid,
		input wr_cmd,
		input wr_idx,
		input wr_data
	);

endinterface

/* rtl/hps_cmd_decoder.sv */
// Host command decoder
// Strobe/ack handshake on the host word channel. The ack is frozen low
// after the vsync wait command until the next vsync rising edge.
// Emits one configuration write per parameter word.

`timescale 1ns/1ps

module hps_cmd_decoder (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_uio,
	input  logic                  i_io_clk,
	input  hps_cmd_pkg::io_word_t i_io_din,
	input  logic                  i_vsync,
	output logic                  o_io_ack,
	cfg_wr_if.src                 o_cfg_wr
);

	logic                   rack;
	logic                   strobe;
	logic                   vs_stall;
	logic                   has_cmd;
	hps_cmd_pkg::cmd_t      cmd;
	hps_cmd_pkg::word_idx_t idx;
	logic                   vs_d0;
	logic                   vs_d1;
	logic                   vs_d2;

	// First cycle of a new host strobe
	assign strobe = ~rack & i_io_clk;

	////////////////////////////////////////////////////////////////////////////
	// Handshake

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack <= 1'b0;
			o_io_ack <= 1'b0;
		end else if (~vs_stall) begin
			rack <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	// Vsync must hold its level for two samples to pass
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			vs_d0 <= 1'b0;
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
		end else begin
			vs_d0 <= i_vsync;
			if (vs_d0 == i_vsync)
				vs_d1 <= vs_d0;
			vs_d2 <= vs_d1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command framing

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd <= '0;
			idx <= '0;
			vs_stall <= 1'b0;
			o_cfg_wr.wr_valid <= 1'b0;
		end else begin
			o_cfg_wr.wr_valid <= 1'b0;
			if (~vs_d2 & vs_d1)
				vs_stall <= 1'b0;

			if (~i_io_uio) begin
				has_cmd <= 1'b0;
				cmd <= '0;
				idx <= '0;
			end else if (strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd <= i_io_din[7:0];
					idx <= '0;
					if (i_io_din[7:0] == hps_cmd_pkg::CMD_VSYNC_WAIT)
						vs_stall <= 1'b1;
				end else begin
					o_cfg_wr.wr_valid <= 1'b1;
					// Stays on the last index for long transfers
					if (~&idx)
						idx <= idx + 1'b1;
				end
			end
		end
	end

	// Write payload
	always_ff @(posedge clk_sys) begin
		if (i_io_uio & strobe & has_cmd) begin
			o_cfg_wr.wr_cmd <= cmd;
			o_cfg_wr.wr_idx <= idx;
			o_cfg_wr.wr_data <= i_io_din;
		end
	end

endmodule

/* rtl/video_cfg_regs.sv */
// Video configuration registers
// Holds the output timing, the LED overtake and the volume attenuation
// written by the host, and the line and frame totals derived from them

`timescale 1ns/1ps

module video_cfg_regs (
	input  logic                                   clk_sys,
	input  logic                                   resetd,
	cfg_wr_if.dst                                  i_cfg_wr,
	output video_timing_pkg::video_timing_t        o_timing,
	output logic [7:0]                             o_led,
	output logic [4:0]                             o_vol_att,
	output logic [video_timing_pkg::TOTAL_W-1:0]   o_htotal,
	output logic [video_timing_pkg::TOTAL_W-1:0]   o_vtotal
);

	logic [7:0]               led_overtake;
	logic [7:0]               led_state;
	video_timing_pkg::coord_t coord;

	assign coord = i_cfg_wr.wr_data[video_timing_pkg::COORD_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_timing <= video_timing_pkg::TIMING_DEFAULT;
			led_overtake <= 8'd0;
			led_state <= 8'd0;
			o_vol_att <= hps_cmd_pkg::VOL_ATT_RESET;
		end else if (i_cfg_wr.wr_valid) begin
			case (i_cfg_wr.wr_cmd)
				hps_cmd_pkg::CMD_VIDEO_TIMING: begin
					case (i_cfg_wr.wr_idx)
						4'd0: o_timing.width <= coord;
						4'd1: o_timing.hfp <= coord;
						4'd2: o_timing.hs <= coord;
						4'd3: o_timing.hbp <= coord;
						4'd4: o_timing.height <= coord;
						4'd5: o_timing.vfp <= coord;
						4'd6: o_timing.vs <= coord;
						4'd7: o_timing.vbp <= coord;
						default: ;
					endcase
				end
				hps_cmd_pkg::CMD_LED: begin
					// Mask in the high byte, state in the low byte
					if (i_cfg_wr.wr_idx == 4'd0)
						{led_overtake, led_state} <= i_cfg_wr.wr_data;
				end
				hps_cmd_pkg::CMD_VOL_ATT: begin
					if (i_cfg_wr.wr_idx == 4'd0)
						o_vol_att <= i_cfg_wr.wr_data[4:0];
				end
				default: ;
			endcase
		end
	end

	// LEDs not taken over by the host stay dark
	assign o_led = led_overtake & led_state;

	// Totals follow the registers one cycle later
	always_ff @(posedge clk_sys) begin
		o_htotal <= o_timing.width + o_timing.hfp + o_timing.hs + o_timing.hbp;
		o_vtotal <= o_timing.height + o_timing.vfp + o_timing.vs + o_timing.vbp;
	end

endmodule

/* rtl/sync_polarity_fix.sv */
// Sync polarity correction
// Measures the last high and low intervals of a sync and inverts it
// when the high part is the longer one, so the pulse comes out active high

`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1 <= 1'b0;
			s2 <= 1'b0;
			cnt <= '0;
			high_len <= '0;
			low_len <= '0;
			pol <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rising edge ends a low interval
			if (~s2 & s1)
				low_len <= cnt;
			if (s2 & ~s1)
				high_len <= cnt;
			if (s2 != s1)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			pol <= high_len > low_len;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

/* rtl/csync_gen.sv */
// Composite sync generator
// Follows hsync outside vsync. During vsync the hsync pulse is moved so
// it starts one hsync width before the next line.

`timescale 1ns/1ps

module csync_gen #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	logic                  prev_hs;
	logic                  csync_hs;
	logic                  hs_next;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;

	// Line length and hsync width
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs <= 1'b0;
			h_cnt <= '0;
			line_len <= '1;
			hs_len <= '0;
		end else begin
			prev_hs <= i_hsync;
			h_cnt <= h_cnt + 1'b1;
			if (prev_hs ^ i_hsync) begin
				h_cnt <= '0;
				if (i_hsync)
					line_len <= h_cnt - hs_len;
				else
					hs_len <= h_cnt;
			end
		end
	end

	always_comb begin
		hs_next = csync_hs;
		if ((prev_hs ^ i_hsync) & i_hsync)
			hs_next = 1'b0;
		if (~i_vsync)
			hs_next = i_hsync;
		else if (h_cnt == line_len)
			hs_next = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			csync_hs <= 1'b0;
			o_csync <= 1'b0;
		end else begin
			csync_hs <= hs_next;
			o_csync <= i_vsync ^ hs_next;
		end
	end

endmodule

/* rtl/hps_video_top.sv */
// Host command channel and sync conditioning
// Decodes configuration commands from the host word channel, holds the
// video configuration and normalizes hsync/vsync with a composite sync

`timescale 1ns/1ps

module hps_video_top #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic                                 clk_sys,
	input  logic                                 resetd,
	input  logic                                 i_io_uio,
	input  logic                                 i_io_clk,
	input  hps_cmd_pkg::io_word_t                i_io_din,
	input  logic                                 i_hs,
	input  logic                                 i_vs,
	output logic                                 o_io_ack,
	output logic                                 o_hs,
	output logic                                 o_vs,
	output logic                                 o_csync,
	output logic [7:0]                           o_led,
	output logic [4:0]                           o_vol_att,
	output video_timing_pkg::coord_t             o_width,
	output video_timing_pkg::coord_t             o_height,
	output logic [video_timing_pkg::TOTAL_W-1:0] o_htotal,
	output logic [video_timing_pkg::TOTAL_W-1:0] o_vtotal
);

	cfg_wr_if cfg_wr ();

	video_timing_pkg::video_timing_t timing;
	logic [1:0]                      sync_raw;
	logic [1:0]                      sync_fix;

	hps_cmd_decoder u_decoder (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_uio (i_io_uio),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.i_vsync  (o_vs),
		.o_io_ack (o_io_ack),
		.o_cfg_wr (cfg_wr)
	);

	video_cfg_regs u_regs (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_cfg_wr  (cfg_wr),
		.o_timing  (timing),
		.o_led     (o_led),
		.o_vol_att (o_vol_att),
		.o_htotal  (o_htotal),
		.o_vtotal  (o_vtotal)
	);

	assign o_width = timing.width;
	assign o_height = timing.height;

	////////////////////////////////////////////////////////////////////////////
	// Sync channels, 0 is hsync and 1 is vsync

	assign sync_raw = {i_vs, i_hs};

	for (genvar g = 0; g < 2; g++) begin : g_sync
		sync_polarity_fix #(
			.SYNC_CNT_W (SYNC_CNT_W)
		) u_fix (
			.clk_sys (clk_sys),
			.resetd  (resetd),
			.i_sync  (sync_raw[g]),
			.o_sync  (sync_fix[g])
		);
	end

	assign o_hs = sync_fix[0];
	assign o_vs = sync_fix[1];

	csync_gen #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) u_csync (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hsync (sync_fix[0]),
		.i_vsync (sync_fix[1]),
		.o_csync (o_csync)
	);

endmodule

/* sim/hps_cmd_decoder_asserts.sv */
// Host command decoder checks
// Write pulses, acknowledge after reset and acknowledge during a vsync wait

`timescale 1ns/1ps

module hps_cmd_decoder_asserts (
	input logic clk_sys,
	input logic resetd,
	input logic i_wr_valid,
	input logic i_io_ack,
	input logic i_vs_stall
);

	int fail_count = 0;

	// One write per host word
	a_wr_single: assert property (@(posedge clk_sys) disable iff (resetd)
		i_wr_valid |=> !i_wr_valid)
		else begin
			$error("write event held high for two cycles");
			fail_count++;
		end

	a_ack_reset: assert property (@(posedge clk_sys) resetd |=> !i_io_ack)
		else begin
			$error("acknowledge high after reset");
			fail_count++;
		end

	// Ack only rises once the stall is gone
	a_ack_stall: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(i_io_ack) |-> !$past(i_vs_stall))
		else begin
			$error("acknowledge rose while the vsync stall was pending");
			fail_count++;
		end

endmodule

/* sim/tb_hps_video_top.sv */
// Testbench for the host command channel and sync conditioning
// Runs the tests of the data file against the top level

`timescale 1ns/1ps

module tb_hps_video_top;

	localparam string TEST_FILE   = "sim/video_cfg_tests.txt";
	localparam int    MAX_TESTS   = 32;
	localparam int    ACK_TIMEOUT = 200;

	logic                                 clk_sys;
	logic                                 resetd;
	logic                                 i_io_uio;
	logic                                 i_io_clk;
	hps_cmd_pkg::io_word_t                i_io_din;
	logic                                 i_hs;
	logic                                 i_vs;
	logic                                 o_io_ack;
	logic                                 o_hs;
	logic                                 o_vs;
	logic                                 o_csync;
	logic [7:0]                           o_led;
	logic [4:0]                           o_vol_att;
	video_timing_pkg::coord_t             o_width;
	video_timing_pkg::coord_t             o_height;
	logic [video_timing_pkg::TOTAL_W-1:0] o_htotal;
	logic [video_timing_pkg::TOTAL_W-1:0] o_vtotal;

	logic [8*24-1:0] test_name [0:MAX_TESTS-1];
	logic [8*8-1:0]  test_kind [0:MAX_TESTS-1];
	logic [15:0]     test_w    [0:MAX_TESTS-1][0:8];
	logic [15:0]     test_e    [0:MAX_TESTS-1][0:3];
	int              num_tests;
	int              max_period;
	bit              loaded;
	string           cur_name;
	int              errors;
	int              test_errors;
	int              seed;

	// Raw sync generator, pulses are active low on the inputs
	int hs_period;
	int hs_width;
	int hs_cnt;
	int vs_period;
	int vs_width;
	int vs_cnt;
	bit hs_pulse;
	bit vs_pulse;
	bit prev_hs_pulse;
	bit prev_vs_pulse;

	hps_video_top #(.SYNC_CNT_W(16)) UUT (.*);

	bind hps_cmd_decoder hps_cmd_decoder_asserts u_asserts (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_wr_valid (o_cfg_wr.wr_valid),
		.i_io_ack   (o_io_ack),
		.i_vs_stall (vs_stall)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Limit scales with the longest sync period in the table
	initial begin
		wait (loaded);
		repeat (num_tests * max_period * 20) @(posedge clk_sys);
		$display("Error: watchdog expired, tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare

	task automatic log_error(input string msg);
		$display("Error in %0s: %0s", cur_name, msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_coord(input string what, input video_timing_pkg::coord_t exp,
		input video_timing_pkg::coord_t act);
		if (act !== exp) begin
			$display("Fail %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_total(input string what,
		input logic [video_timing_pkg::TOTAL_W-1:0] exp,
		input logic [video_timing_pkg::TOTAL_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_led(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %0s o_led expected %h actual %h", cur_name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_vol(input logic [4:0] exp, input logic [4:0] act);
		if (act !== exp) begin
			$display("Fail %0s o_vol_att expected %0d actual %0d", cur_name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %0s %0s expected %b actual %b at %0t", cur_name, what, exp, act,
				$time);
			errors++;
			test_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test table

	task automatic load_tests(output bit ok);
		int               fd;
		int               n;
		int               p;
		logic [8*256-1:0] line;
		num_tests = 0;
		max_period = 64;
		fd = $fopen(TEST_FILE, "r");
		if (fd != 0) begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				line = '0;
				n = $fgets(line, fd);
				n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h",
					test_name[num_tests], test_kind[num_tests],
					test_w[num_tests][0], test_w[num_tests][1], test_w[num_tests][2],
					test_w[num_tests][3], test_w[num_tests][4], test_w[num_tests][5],
					test_w[num_tests][6], test_w[num_tests][7], test_w[num_tests][8],
					test_e[num_tests][0], test_e[num_tests][1],
					test_e[num_tests][2], test_e[num_tests][3]);
				// Comment lines stop after two fields
				if (n == 15) begin
					if (test_kind[num_tests] == "sync") begin
						p = int'(test_w[num_tests][0]) + int'(test_w[num_tests][1]);
						p = p * (int'(test_w[num_tests][3]) + int'(test_w[num_tests][4]));
						if (p > max_period)
							max_period = p;
					end
					num_tests++;
				end
			end
			$fclose(fd);
		end
		ok = num_tests > 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host word channel

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic wait_ack(input logic level, output bit ok);
		int n;
		n = 0;
		ok = 1'b0;
		while (!ok && n < ACK_TIMEOUT) begin
			@(posedge clk_sys);
			#1;
			n++;
			if (o_io_ack === level)
				ok = 1'b1;
		end
	endtask

	task automatic send_word(input hps_cmd_pkg::io_word_t word);
		bit ok;
		@(posedge clk_sys);
		#1;
		i_io_din = word;
		i_io_clk = 1'b1;
		wait_ack(1'b1, ok);
		if (!ok)
			log_error($sformatf("no acknowledge for word %h", word));
		i_io_clk = 1'b0;
		wait_ack(1'b0, ok);
		if (!ok)
			log_error($sformatf("acknowledge stuck high after word %h", word));
	endtask

	// Command word first, then its parameters
	task automatic send_transfer(input int t, input int first, input int count);
		int i;
		@(posedge clk_sys);
		#1;
		i_io_uio = 1'b1;
		for (i = first; i < first + count; i++)
			send_word(test_w[t][i]);
		@(posedge clk_sys);
		#1;
		i_io_uio = 1'b0;
		idle(3);
	endtask

	task automatic run_vsync_wait(input int t);
		bit ok;
		bit held;
		int i;
		held = 1'b1;
		@(posedge clk_sys);
		#1;
		i_io_uio = 1'b1;
		i_io_din = test_w[t][0];
		i_io_clk = 1'b1;
		for (i = 0; i < int'(test_w[t][3]); i++) begin
			@(posedge clk_sys);
			#1;
			if (o_io_ack !== 1'b0)
				held = 1'b0;
		end
		if (!held)
			log_error("acknowledge rose while vsync was held low");
		i_vs = 1'b1;
		wait_ack(1'b1, ok);
		if (!ok)
			log_error("acknowledge not released by the vsync rising edge");
		i_io_clk = 1'b0;
		wait_ack(1'b0, ok);
		if (!ok)
			log_error("acknowledge stuck high after the vsync wait");
		i_vs = 1'b0;
		i_io_uio = 1'b0;
		idle(3);
		send_transfer(t, 1, 2);
		check_vol(test_e[t][0][4:0], o_vol_att);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sync stimulus

	// One clock of both syncs, ends at the falling edge
	task automatic step_syncs();
		prev_hs_pulse = hs_pulse;
		prev_vs_pulse = vs_pulse;
		@(posedge clk_sys);
		#1;
		hs_pulse = hs_cnt < hs_width;
		vs_pulse = vs_cnt < vs_width;
		i_hs = ~hs_pulse;
		i_vs = ~vs_pulse;
		hs_cnt = (hs_cnt == hs_period - 1) ? 0 : hs_cnt + 1;
		vs_cnt = (vs_cnt == vs_period - 1) ? 0 : vs_cnt + 1;
		@(negedge clk_sys);
	endtask

	task automatic run_sync_fix(input int t);
		int r;
		int i;
		int settle;
		r = $random(seed);
		hs_period = int'(test_w[t][0]) + (r & 'h7fff_ffff) % int'(test_w[t][1]);
		hs_width = int'(test_w[t][2]);
		r = $random(seed);
		vs_period = int'(test_w[t][3]) + (r & 'h7fff_ffff) % int'(test_w[t][4]);
		vs_period = vs_period * hs_period;
		vs_width = int'(test_w[t][5]) * hs_period;
		hs_cnt = 0;
		vs_cnt = 0;
		settle = 2 * vs_period + 4;
		for (i = 0; i < settle + vs_period; i++) begin
			step_syncs();
			if (i >= settle && test_errors == 0) begin
				check_bit("o_hs", hs_pulse ? test_e[t][0][0] : test_e[t][1][0], o_hs);
				check_bit("o_vs", vs_pulse ? test_e[t][0][0] : test_e[t][1][0], o_vs);
			end
		end
	endtask

	// Outside vsync the composite sync is last cycle's hsync
	task automatic run_csync(input int t);
		int i;
		for (i = 0; i < int'(test_w[t][0]); i++) begin
			step_syncs();
			if (!prev_vs_pulse && test_errors == 0)
				check_bit("o_csync", prev_hs_pulse ? test_e[t][0][0] : test_e[t][1][0],
					o_csync);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	task automatic run_test(input int t);
		cur_name = $sformatf("%0s", test_name[t]);
		test_errors = 0;
		case (test_kind[t])
			"reset": begin
				check_total("o_htotal", test_e[t][0][12:0], o_htotal);
				check_total("o_vtotal", test_e[t][1][12:0], o_vtotal);
				check_led(test_e[t][2][7:0], o_led);
				check_vol(test_e[t][3][4:0], o_vol_att);
			end
			"timing": begin
				send_transfer(t, 0, 9);
				check_coord("o_width", test_e[t][0][11:0], o_width);
				check_coord("o_height", test_e[t][1][11:0], o_height);
				check_total("o_htotal", test_e[t][2][12:0], o_htotal);
				check_total("o_vtotal", test_e[t][3][12:0], o_vtotal);
			end
			"led": begin
				send_transfer(t, 0, 2);
				check_led(test_e[t][0][7:0], o_led);
			end
			"vol": begin
				send_transfer(t, 0, 2);
				check_vol(test_e[t][0][4:0], o_vol_att);
			end
			"vwait": run_vsync_wait(t);
			"sync": run_sync_fix(t);
			"csync": run_csync(t);
			default: log_error($sformatf("unknown test kind %0s", test_kind[t]));
		endcase
		$display("%0s finished with %0d errors", cur_name, test_errors);
	endtask

	initial begin : main
		bit ok;
		int t;
		int passed;
		int assert_fails;
		resetd = 1'b1;
		i_io_uio = 1'b0;
		i_io_clk = 1'b0;
		i_io_din = '0;
		i_hs = 1'b0;
		i_vs = 1'b0;
		errors = 0;
		passed = 0;
		seed = 42115;
		hs_pulse = 1'b0;
		vs_pulse = 1'b0;
		load_tests(ok);
		if (!ok) begin
			$display("Error: no tests could be read from %0s", TEST_FILE);
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (4) @(posedge clk_sys);
			#1;
			resetd = 1'b0;
			idle(3);
			for (t = 0; t < num_tests; t++) begin
				run_test(t);
				if (test_errors == 0)
					passed++;
			end
			assert_fails = UUT.u_decoder.u_asserts.fail_count;
			$display("Tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
				num_tests, passed, num_tests - passed, errors, assert_fails);
			if (errors == 0 && assert_fails == 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

/* project.f */
rtl/hps_cmd_pkg.sv
rtl/video_timing_pkg.sv
rtl/cfg_wr_if.sv
rtl/hps_cmd_decoder.sv
rtl/video_cfg_regs.sv
rtl/sync_polarity_fix.sv
rtl/csync_gen.sv
rtl/hps_video_top.sv
sim/hps_cmd_decoder_asserts.sv
sim/tb_hps_video_top.sv

/* Bender.yml */
package:
  name: hps_video

sources:
  - rtl/hps_cmd_pkg.sv
  - rtl/video_timing_pkg.sv
  - rtl/cfg_wr_if.sv
  - rtl/hps_cmd_decoder.sv
  - rtl/video_cfg_regs.sv
  - rtl/sync_polarity_fix.sv
  - rtl/csync_gen.sv
  - rtl/hps_video_top.sv
  - target: simulation
    files:
      - sim/hps_cmd_decoder_asserts.sv
      - sim/tb_hps_video_top.sv

/* sim/video_cfg_tests.txt */
# name kind w0..w8 (hex words, command word first) e0..e3 (hex expected values)
# sync rows use w0..w5 as base, spread, width, lines base, lines spread, pulse lines
reset_defaults  reset  0000 0000 0000 0000 0000 0000 0000 0000 0000 0898 0465 0000 001F
timing_720p     timing 0020 0500 006E 0028 00DC 02D0 0005 0005 0014 0500 02D0 0672 02EE
timing_masked   timing 0020 F320 1028 8080 0058 2258 0001 4004 0017 0320 0258 0420 0274
led_overtake    led    0025 F05A 0000 0000 0000 0000 0000 0000 0000 0050 0000 0000 0000
led_partial     led    0025 3CA5 0000 0000 0000 0000 0000 0000 0000 0024 0000 0000 0000
vol_low_bits    vol    0026 FFEA 0000 0000 0000 0000 0000 0000 0000 000A 0000 0000 0000
vsync_wait      vwait  0030 0026 0013 0020 0000 0000 0000 0000 0000 0013 0000 0000 0000
vol_after_wait  vol    0026 0015 0000 0000 0000 0000 0000 0000 0000 0015 0000 0000 0000
sync_active_low sync   0028 0020 0006 0004 0004 0001 0000 0000 0000 0001 0000 0000 0000
csync_follow    csync  0400 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000
